// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_dcache
RTL_TOP    := dcache_top
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module data_array (
	input  wire                     i_clk,
	input  wire  [`INDEX_W-1:0]     i_index,
	input  wire  [`WAY_W-1:0]       i_way,
	input  wire  [`WORD_OFF_W-1:0]  i_word,
	input  wire                     i_word_we,
	input  wire  [3:0]              i_be,
	input  wire  [31:0]             i_wdata,
	input  wire                     i_line_we,
	input  wire  [`LINE_BITS-1:0]   i_wline,
	output logic [31:0]             o_rword,
	output logic [`LINE_BITS-1:0]   o_rline
);
	logic [31:0]           mem [`CACHE_WAYS][`CACHE_SETS][`WORDS_PER_LINE];
	logic [`LINE_BITS-1:0] rd_lines [`CACHE_WAYS];

	always_ff @(posedge i_clk) begin
		if (i_line_we) begin
			for (int w = 0; w < `WORDS_PER_LINE; w++) begin
				mem[i_way][i_index][w] <= i_wline[w*32 +: 32];
			end
		end
		// byte lanes of one word
		if (i_word_we) begin
			for (int b = 0; b < 4; b++) begin
				if (i_be[b])
					mem[i_way][i_index][i_word][b*8 +: 8] <= i_wdata[b*8 +: 8];
			end
		end
	end

	// whole set read and the way picked a cycle later
	always_ff @(posedge i_clk) begin
		for (int v = 0; v < `CACHE_WAYS; v++) begin
			for (int w = 0; w < `WORDS_PER_LINE; w++) begin
				rd_lines[v][w*32 +: 32] <= mem[v][i_index][w];
			end
		end
	end

	assign o_rline = rd_lines[i_way];
	assign o_rword = o_rline[i_word*32 +: 32];

endmodule

`default_nettype wire

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input  wire                     i_clk,
	input  wire                     i_rst,
	input  wire                     i_req,
	input  wire                     i_we,
	input  wire  [31:0]             i_addr,
	input  wire  [3:0]              i_be,
	input  wire  [31:0]             i_wdata,
	output logic                    o_ack,
	output logic [31:0]             o_rdata,
	output logic [`INDEX_W-1:0]     o_tag_index,
	output logic                    o_tag_we,
	output logic [`INDEX_W-1:0]     o_tag_windex,
	output logic                    o_tag_wvalid,
	output logic [`TAG_W-1:0]       o_tag_wtag,
	input  wire                     i_hit,
	input  wire  [`WAY_W-1:0]       i_hit_way,
	input  wire  [`TAG_W:0]         i_victim_valid_tag,
	output logic [`INDEX_W-1:0]     o_data_index,
	output logic [`WAY_W-1:0]       o_data_way,
	output logic [`WORD_OFF_W-1:0]  o_data_word,
	output logic [3:0]              o_data_be,
	output logic [31:0]             o_data_wdata,
	output logic                    o_data_word_we,
	output logic                    o_data_line_we,
	output logic [`LINE_BITS-1:0]   o_data_line,
	input  wire  [31:0]             i_data_rword,
	input  wire  [`LINE_BITS-1:0]   i_data_rline,
	output logic [`INDEX_W-1:0]     o_lru_index,
	output logic                    o_lru_touch,
	output logic [`WAY_W-1:0]       o_lru_way,
	input  wire  [`WAY_W-1:0]       i_lru_victim,
	mem_cmd_if.ctrl                 mem
);
	localparam logic [2:0] ST_INVALIDATING = 3'd0;
	localparam logic [2:0] ST_IDLE         = 3'd1;
	localparam logic [2:0] ST_LOOKUP       = 3'd2;
	localparam logic [2:0] ST_WRITEBACK    = 3'd3;
	localparam logic [2:0] ST_REFILL       = 3'd4;
	localparam logic [2:0] ST_RESPOND      = 3'd5;

	logic [2:0]            state;
	logic [`INDEX_W-1:0]   sweep_cnt;
	addr_u                 cur_addr;
	addr_u                 req_addr;
	logic                  req_we;
	logic [3:0]            req_be;
	logic [31:0]           req_wdata;
	logic [`WAY_W-1:0]     fill_way;
	logic [`INDEX_W-1:0]   rd_index;
	logic [`WAY_W-1:0]     lookup_way;
	logic                  lookup_hit;
	logic                  victim_valid;
	logic                  wb_done;
	logic                  fill_done;
	logic [31:0]           wb_addr;
	logic [31:0]           fill_addr;
	logic [31:0]           fill_word;
	logic [`LINE_BITS-1:0] fill_line;

	assign cur_addr.raw = i_addr;

	// arrays are read with the live address while idle
	assign rd_index     = (state == ST_IDLE) ? cur_addr.f.index : req_addr.f.index;
	assign lookup_hit   = (state == ST_LOOKUP) && i_hit;
	assign lookup_way   = i_hit ? i_hit_way : i_lru_victim;
	assign victim_valid = i_victim_valid_tag[`TAG_W];
	assign wb_done      = (state == ST_WRITEBACK) && mem.done;
	assign fill_done    = (state == ST_REFILL) && mem.done;

	assign wb_addr   = {i_victim_valid_tag[`TAG_W-1:0], req_addr.f.index,
		{(`WORD_OFF_W + 2){1'b0}}};
	assign fill_addr = {req_addr.f.tag, req_addr.f.index, {(`WORD_OFF_W + 2){1'b0}}};

	// pending write bytes go into the refilled line
	always_comb begin
		fill_line = mem.rline;
		fill_word = mem.rline[req_addr.f.word*32 +: 32];
		if (req_we) begin
			for (int b = 0; b < 4; b++) begin
				if (req_be[b])
					fill_word[b*8 +: 8] = req_wdata[b*8 +: 8];
			end
			fill_line[req_addr.f.word*32 +: 32] = fill_word;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state     <= ST_INVALIDATING;
			sweep_cnt <= '0;
			mem.start <= 1'b0;
		end else begin
			mem.start <= 1'b0;
			case (state)
				ST_INVALIDATING: begin
					sweep_cnt <= sweep_cnt + 1'b1;
					if (sweep_cnt == `INDEX_W'(`CACHE_SETS - 1))
						state <= ST_IDLE;
				end
				ST_IDLE: begin
					if (i_req)
						state <= ST_LOOKUP;
				end
				ST_LOOKUP: begin
					if (i_hit) begin
						state <= ST_RESPOND;
					end else begin
						mem.start <= 1'b1;
						state     <= victim_valid ? ST_WRITEBACK : ST_REFILL;
					end
				end
				ST_WRITEBACK: begin
					if (wb_done) begin
						mem.start <= 1'b1;
						state     <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (fill_done)
						state <= ST_RESPOND;
				end
				ST_RESPOND: begin
					// hold ack until the core lets go
					if (!i_req)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && i_req) begin
			req_addr  <= cur_addr;
			req_we    <= i_we;
			req_be    <= i_be;
			req_wdata <= i_wdata;
		end
		if (state == ST_LOOKUP) begin
			o_rdata <= i_data_rword;
			if (!i_hit) begin
				// victim line leaves with its current contents
				fill_way  <= i_lru_victim;
				mem.wline <= i_data_rline;
				mem.we    <= victim_valid;
				mem.addr  <= victim_valid ? wb_addr : fill_addr;
			end
		end
		if (wb_done) begin
			mem.we   <= 1'b0;
			mem.addr <= fill_addr;
		end
		if (fill_done)
			o_rdata <= fill_word;
	end

	assign o_ack = (state == ST_RESPOND);

	// sweep writes an invalid entry, which clears the whole set
	assign o_tag_index  = rd_index;
	assign o_tag_we     = (state == ST_INVALIDATING) || fill_done;
	assign o_tag_windex = (state == ST_INVALIDATING) ? sweep_cnt : req_addr.f.index;
	assign o_tag_wvalid = (state != ST_INVALIDATING);
	assign o_tag_wtag   = req_addr.f.tag;

	assign o_data_index   = rd_index;
	assign o_data_way     = (state == ST_LOOKUP) ? lookup_way : fill_way;
	assign o_data_word    = req_addr.f.word;
	assign o_data_be      = req_be;
	assign o_data_wdata   = req_wdata;
	assign o_data_word_we = lookup_hit && req_we;
	assign o_data_line_we = fill_done;
	assign o_data_line    = fill_line;

	// hit touches the hit way, miss the victim
	assign o_lru_index = rd_index;
	assign o_lru_touch = (state == ST_LOOKUP);
	assign o_lru_way   = lookup_way;

endmodule

`default_nettype wire

// File: hw/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
`define CACHE_WAYS      4
`define CACHE_SETS      16
`define WORDS_PER_LINE  8

// address split into tag, index, word offset and 2 byte bits
`define WORD_OFF_W      3
`define INDEX_W         4
`define TAG_W           23

// way number and tree pseudo-LRU state
`define WAY_W           2
`define PLRU_W          3

// one line on the memory bus
`define LINE_BITS       256

`endif

// File: hw/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	// byte address as the cache sees it
	typedef struct packed {
		logic [`TAG_W-1:0]      tag;
		logic [`INDEX_W-1:0]    index;
		logic [`WORD_OFF_W-1:0] word;
		logic [1:0]             byte_off;
	} addr_fields_t;

	// raw word or split fields
	typedef union packed {
		logic [31:0]  raw;
		addr_fields_t f;
	} addr_u;

endpackage

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top (
	input  wire                   i_clk,
	input  wire                   i_rst,
	input  wire                   i_req,
	input  wire                   i_we,
	input  wire  [31:0]           i_addr,
	input  wire  [3:0]            i_be,
	input  wire  [31:0]           i_wdata,
	output logic                  o_ack,
	output logic [31:0]           o_rdata,
	output logic                  o_mem_req,
	output logic                  o_mem_we,
	output logic [31:0]           o_mem_addr,
	output logic [`LINE_BITS-1:0] o_mem_wline,
	input  wire                   i_mem_ack,
	input  wire  [`LINE_BITS-1:0] i_mem_rline
);
	logic [`INDEX_W-1:0]    tag_index;
	logic                   tag_we;
	logic [`INDEX_W-1:0]    tag_windex;
	logic                   tag_wvalid;
	logic [`TAG_W-1:0]      tag_wtag;
	logic                   hit;
	logic [`WAY_W-1:0]      hit_way;
	logic [`TAG_W:0]        victim_valid_tag;
	logic [`INDEX_W-1:0]    data_index;
	logic [`WAY_W-1:0]      data_way;
	logic [`WORD_OFF_W-1:0] data_word;
	logic [3:0]             data_be;
	logic [31:0]            data_wdata;
	logic                   data_word_we;
	logic                   data_line_we;
	logic [`LINE_BITS-1:0]  data_line;
	logic [31:0]            data_rword;
	logic [`LINE_BITS-1:0]  data_rline;
	logic [`INDEX_W-1:0]    lru_index;
	logic                   lru_touch;
	logic [`WAY_W-1:0]      lru_way;
	logic [`WAY_W-1:0]      lru_victim;

	mem_cmd_if mem_cmd ();

	dcache_ctrl u_ctrl (
		.i_clk,
		.i_rst,
		.i_req,
		.i_we,
		.i_addr,
		.i_be,
		.i_wdata,
		.o_ack,
		.o_rdata,
		.o_tag_index        (tag_index),
		.o_tag_we           (tag_we),
		.o_tag_windex       (tag_windex),
		.o_tag_wvalid       (tag_wvalid),
		.o_tag_wtag         (tag_wtag),
		.i_hit              (hit),
		.i_hit_way          (hit_way),
		.i_victim_valid_tag (victim_valid_tag),
		.o_data_index       (data_index),
		.o_data_way         (data_way),
		.o_data_word        (data_word),
		.o_data_be          (data_be),
		.o_data_wdata       (data_wdata),
		.o_data_word_we     (data_word_we),
		.o_data_line_we     (data_line_we),
		.o_data_line        (data_line),
		.i_data_rword       (data_rword),
		.i_data_rline       (data_rline),
		.o_lru_index        (lru_index),
		.o_lru_touch        (lru_touch),
		.o_lru_way          (lru_way),
		.i_lru_victim       (lru_victim),
		.mem                (mem_cmd.ctrl)
	);

	// tag writes go to the way the data side is pointed at
	tag_array u_tag (
		.i_clk,
		.i_we               (tag_we),
		.i_windex           (tag_windex),
		.i_wway             (data_way),
		.i_wvalid           (tag_wvalid),
		.i_wtag             (tag_wtag),
		.i_index            (tag_index),
		.i_addr,
		.i_victim_way       (lru_victim),
		.o_hit              (hit),
		.o_hit_way          (hit_way),
		.o_victim_valid_tag (victim_valid_tag)
	);

	data_array u_data (
		.i_clk,
		.i_index   (data_index),
		.i_way     (data_way),
		.i_word    (data_word),
		.i_word_we (data_word_we),
		.i_be      (data_be),
		.i_wdata   (data_wdata),
		.i_line_we (data_line_we),
		.i_wline   (data_line),
		.o_rword   (data_rword),
		.o_rline   (data_rline)
	);

	plru u_plru (
		.i_clk,
		.i_rst,
		.i_index  (lru_index),
		.i_touch  (lru_touch),
		.i_way    (lru_way),
		.o_victim (lru_victim)
	);

	mem_bridge u_bridge (
		.i_clk,
		.i_rst,
		.cmd (mem_cmd.port),
		.o_mem_req,
		.o_mem_we,
		.o_mem_addr,
		.o_mem_wline,
		.i_mem_ack,
		.i_mem_rline
	);

endmodule

`default_nettype wire

// File: hw/mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module mem_bridge (
	input  wire                   i_clk,
	input  wire                   i_rst,
	mem_cmd_if.port               cmd,
	output logic                  o_mem_req,
	output logic                  o_mem_we,
	output logic [31:0]           o_mem_addr,
	output logic [`LINE_BITS-1:0] o_mem_wline,
	input  wire                   i_mem_ack,
	input  wire  [`LINE_BITS-1:0] i_mem_rline
);
	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_REQ     = 2'd1;
	localparam logic [1:0] ST_RELEASE = 2'd2;

	logic [1:0] state;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state     <= ST_IDLE;
			o_mem_req <= 1'b0;
			cmd.done  <= 1'b0;
		end else begin
			cmd.done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cmd.start) begin
						o_mem_req <= 1'b1;
						state     <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (i_mem_ack) begin
						o_mem_req <= 1'b0;
						state     <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					// done only once memory has released ack
					if (!i_mem_ack) begin
						cmd.done <= 1'b1;
						state    <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// command held steady for the whole request phase
	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && cmd.start) begin
			o_mem_we    <= cmd.we;
			o_mem_addr  <= cmd.addr;
			o_mem_wline <= cmd.wline;
		end
		if (state == ST_REQ && i_mem_ack && !o_mem_we)
			cmd.rline <= i_mem_rline;
	end

endmodule

`default_nettype wire

// File: hw/mem_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

interface mem_cmd_if;
	logic                  start;
	logic                  we;
	logic [31:0]           addr;
	logic [`LINE_BITS-1:0] wline;
	logic                  done;
	logic [`LINE_BITS-1:0] rline;

	// controller issues, bridge answers
	modport ctrl (
		output start,
		output we,
		output addr,
		output wline,
		input  done,
		input  rline
	);

	modport port (
		input  start,
		input  we,
		input  addr,
		input  wline,
		output done,
		output rline
	);
endinterface

`default_nettype wire

// File: hw/plru.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module plru (
	input  wire                 i_clk,
	input  wire                 i_rst,
	input  wire  [`INDEX_W-1:0] i_index,
	input  wire                 i_touch,
	input  wire  [`WAY_W-1:0]   i_way,
	output logic [`WAY_W-1:0]   o_victim
);
	logic [`PLRU_W-1:0] tree [`CACHE_SETS];
	logic [`PLRU_W-1:0] rd_bits;
	logic [`PLRU_W-1:0] new_bits;

	// bit 1 root, bit 0 over ways 0/1, bit 2 over ways 2/3
	always_comb begin
		new_bits = tree[i_index];
		case (i_way)
			2'd0:    new_bits[1:0] = 2'b00;
			2'd1:    new_bits[1:0] = 2'b01;
			2'd2:    new_bits[2:1] = 2'b01;
			default: new_bits[2:1] = 2'b11;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				tree[s] <= '0;
			end
		end else if (i_touch) begin
			tree[i_index] <= new_bits;
		end
	end

	always_ff @(posedge i_clk) begin
		rd_bits <= tree[i_index];
	end

	// victim points away from the recently used half
	always_comb begin
		if (!rd_bits[1])
			o_victim = rd_bits[2] ? 2'd2 : 2'd3;
		else
			o_victim = rd_bits[0] ? 2'd0 : 2'd1;
	end

endmodule

`default_nettype wire

// File: hw/tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tag_array
	import dcache_pkg::*;
(
	input  wire                  i_clk,
	input  wire                  i_we,
	input  wire  [`INDEX_W-1:0]  i_windex,
	input  wire  [`WAY_W-1:0]    i_wway,
	input  wire                  i_wvalid,
	input  wire  [`TAG_W-1:0]    i_wtag,
	input  wire  [`INDEX_W-1:0]  i_index,
	input  wire  [31:0]          i_addr,
	input  wire  [`WAY_W-1:0]    i_victim_way,
	output logic                 o_hit,
	output logic [`WAY_W-1:0]    o_hit_way,
	output logic [`TAG_W:0]      o_victim_valid_tag
);
	// {valid, tag} per way and set
	logic [`TAG_W:0]         mem [`CACHE_WAYS][`CACHE_SETS];
	logic [`TAG_W:0]         rd_set [`CACHE_WAYS];
	addr_u                   req_addr;
	logic [`CACHE_WAYS-1:0]  way_hit;

	// an invalid write clears every way of the set
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (i_we && (!i_wvalid || i_wway == `WAY_W'(w)))
				mem[w][i_windex] <= {i_wvalid, i_wtag};
		end
	end

	// address registered alongside the set read
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			rd_set[w] <= mem[w][i_index];
		end
		req_addr.raw <= i_addr;
	end

	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_hit[w] = rd_set[w][`TAG_W] && (rd_set[w][`TAG_W-1:0] == req_addr.f.tag);
			if (way_hit[w])
				o_hit_way = `WAY_W'(w);
		end
		o_hit = |way_hit;
	end

	assign o_victim_valid_tag = rd_set[i_victim_way];

endmodule

`default_nettype wire

// File: sim/dcache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_asserts (
	input wire                  i_clk,
	input wire                  i_rst,
	input wire                  i_req,
	input wire                  o_ack,
	input wire                  o_mem_req,
	input wire                  o_mem_we,
	input wire [31:0]           o_mem_addr,
	input wire [`LINE_BITS-1:0] o_mem_wline
);
	// ack only answers a request seen on the edge before
	ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
		o_ack |-> $past(i_req))
		else $error("o_ack high without i_req at the preceding edge");

	// command fields frozen while the memory request is up
	mem_cmd_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_mem_req && $past(o_mem_req)) |->
		($stable(o_mem_we) && $stable(o_mem_addr) && $stable(o_mem_wline)))
		else $error("memory command changed while o_mem_req was high");

	mem_addr_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_req |-> (o_mem_addr[4:0] == 5'd0))
		else $error("o_mem_addr not line aligned");

	quiet_in_reset: assert property (@(posedge i_clk)
		(i_rst && $past(i_rst)) |-> (!o_ack && !o_mem_req))
		else $error("o_ack or o_mem_req high during reset");

endmodule

bind dcache_top dcache_asserts u_asserts (.*);

`default_nettype wire

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
	output logic o_clk,
	output logic o_rst
);
	// 8 ns period
	initial o_clk = 1'b0;
	always #4 o_clk = ~o_clk;

	initial begin
		o_rst = 1'b1;
		repeat (4) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tb_dcache;
	localparam int TIMEOUT = 400;

	logic                  clk;
	logic                  rst;
	logic                  i_req;
	logic                  i_we;
	logic [31:0]           i_addr;
	logic [3:0]            i_be;
	logic [31:0]           i_wdata;
	logic                  o_ack;
	logic [31:0]           o_rdata;
	logic                  o_mem_req;
	logic                  o_mem_we;
	logic [31:0]           o_mem_addr;
	logic [`LINE_BITS-1:0] o_mem_wline;
	logic                  mem_ack;
	logic [`LINE_BITS-1:0] mem_rline;

	// backing memory and the core's view of it keyed by word address
	logic [31:0] mem_words [logic [31:0]];
	logic [31:0] shadow [logic [31:0]];
	logic [31:0] exp_q [$];
	logic        read_q [$];

	int          errors;
	int          tests_run;
	int          tests_failed;
	int          rd_cnt;
	int          wr_cnt;
	int          mem_delay;
	logic        mem_busy;
	logic [31:0] last_rd_addr;
	logic [31:0] last_wr_addr;
	logic [`LINE_BITS-1:0] last_wr_line;
	logic        ack_seen;
	int          last_lat;
	int          rd_delta;
	int          wr_delta;

	tb_clkgen u_clkgen (
		.o_clk (clk),
		.o_rst (rst)
	);

	dcache_top dut0 (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_req       (i_req),
		.i_we        (i_we),
		.i_addr      (i_addr),
		.i_be        (i_be),
		.i_wdata     (i_wdata),
		.o_ack       (o_ack),
		.o_rdata     (o_rdata),
		.o_mem_req   (o_mem_req),
		.o_mem_we    (o_mem_we),
		.o_mem_addr  (o_mem_addr),
		.o_mem_wline (o_mem_wline),
		.i_mem_ack   (mem_ack),
		.i_mem_rline (mem_rline)
	);

	function automatic logic [31:0] init_word(input logic [31:0] a);
		return {a[15:0], a[31:16]} ^ (a << 7) ^ 32'hc3a5_0f1e;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] a);
		if (mem_words.exists(a))
			return mem_words[a];
		return init_word(a);
	endfunction

	function automatic logic [31:0] byte_merge(input logic [31:0] old,
		input logic [31:0] wdata, input logic [3:0] be);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				r[b*8 +: 8] = wdata[b*8 +: 8];
		end
		return r;
	endfunction

	// expected read word as the core should see it
	function automatic logic [31:0] ref_word(input logic [31:0] a);
		logic [31:0] wa;
		wa = {a[31:2], 2'b00};
		if (shadow.exists(wa))
			return shadow[wa];
		return init_word(wa);
	endfunction

	function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
		return {tag[22:0], set[3:0], word[2:0], 2'b00};
	endfunction

	// tree rule with bit 1 as the root
	function automatic logic [1:0] plru_victim(input logic [2:0] t);
		if (!t[1])
			return t[2] ? 2'd2 : 2'd3;
		return t[0] ? 2'd0 : 2'd1;
	endfunction

	function automatic logic [2:0] plru_touch(input logic [2:0] t, input logic [1:0] way);
		logic [2:0] r;
		r = t;
		case (way)
			2'd0: begin
				r[1] = 1'b0;
				r[0] = 1'b0;
			end
			2'd1: begin
				r[1] = 1'b0;
				r[0] = 1'b1;
			end
			2'd2: begin
				r[1] = 1'b1;
				r[2] = 1'b0;
			end
			default: begin
				r[1] = 1'b1;
				r[2] = 1'b1;
			end
		endcase
		return r;
	endfunction

	task automatic end_run();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout: %s", what);
		errors++;
		end_run();
	endtask

	task automatic report(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	// memory side answering after 0 to 5 cycles
	always @(negedge clk) begin
		logic [`LINE_BITS-1:0] line;
		if (rst) begin
			mem_ack  = 1'b0;
			mem_busy = 1'b0;
		end else if (mem_ack) begin
			if (!o_mem_req)
				mem_ack = 1'b0;
		end else if (o_mem_req) begin
			if (!mem_busy) begin
				mem_busy  = 1'b1;
				mem_delay = $urandom_range(0, 5);
			end
			if (mem_delay == 0) begin
				mem_busy = 1'b0;
				if (o_mem_we) begin
					for (int w = 0; w < `WORDS_PER_LINE; w++)
						mem_words[o_mem_addr + 32'(w*4)] = o_mem_wline[w*32 +: 32];
					wr_cnt++;
					last_wr_addr = o_mem_addr;
					last_wr_line = o_mem_wline;
				end else begin
					for (int w = 0; w < `WORDS_PER_LINE; w++)
						line[w*32 +: 32] = mem_word(o_mem_addr + 32'(w*4));
					mem_rline = line;
					rd_cnt++;
					last_rd_addr = o_mem_addr;
				end
				mem_ack = 1'b1;
			end else begin
				mem_delay--;
			end
		end
	end

	// compare process pops one queue entry per access
	always @(negedge clk) begin
		logic [31:0] exp_word;
		logic        is_read;
		if (!o_ack) begin
			ack_seen = 1'b0;
		end else if (!ack_seen) begin
			ack_seen = 1'b1;
			assert (exp_q.size() != 0) else begin
				$display("o_ack rose with no request outstanding");
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				is_read  = read_q.pop_front();
				if (is_read) begin
					assert (o_rdata == exp_word) else begin
						$display("[FAIL] o_rdata: got %h expected %h", o_rdata, exp_word);
						errors++;
					end
				end
			end
		end
	end

	// one full core handshake starting on a falling edge
	task automatic access(input logic we, input logic [31:0] addr, input logic [3:0] be,
		input logic [31:0] wdata, input int hold);
		int n;
		int rd0;
		int wr0;
		rd0 = rd_cnt;
		wr0 = wr_cnt;
		exp_q.push_back(we ? 32'h0 : ref_word(addr));
		read_q.push_back(!we);
		if (we)
			shadow[{addr[31:2], 2'b00}] = byte_merge(ref_word(addr), wdata, be);
		i_req   = 1'b1;
		i_we    = we;
		i_addr  = addr;
		i_be    = be;
		i_wdata = wdata;
		n = 0;
		while (!o_ack) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				timeout_fail("o_ack never rose");
		end
		last_lat = n;
		repeat (hold) begin
			@(negedge clk);
			assert (o_ack) else begin
				$display("o_ack fell while i_req was still high");
				errors++;
			end
		end
		i_req = 1'b0;
		n = 0;
		while (o_ack) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				timeout_fail("o_ack never fell");
		end
		rd_delta = rd_cnt - rd0;
		wr_delta = wr_cnt - wr0;
	endtask

	task automatic check_int(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	initial begin
		int          e0;
		int          n;
		logic [31:0] a;
		logic [2:0]  tree;
		int          way_tag [4];
		logic        way_valid [4];
		logic [1:0]  v;
		int          evicted;
		i_req     = 1'b0;
		i_we      = 1'b0;
		i_addr    = '0;
		i_be      = '0;
		i_wdata   = '0;
		mem_ack   = 1'b0;
		mem_rline = '0;
		mem_busy  = 1'b0;
		ack_seen  = 1'b0;
		void'($urandom(32'h63badb2a));

		n = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > 20)
				timeout_fail("reset never released");
		end

		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			a = 32'h1000 + 32'(i*32) + 32'(i*4);
			access(1'b0, a, 4'h0, 32'h0, 0);
			check_int("mem reads", rd_delta, 1);
			check_int("mem writes", wr_delta, 0);
			check_int("o_mem_addr", last_rd_addr, {a[31:5], 5'd0});
		end
		report("cold reads", e0);

		e0 = errors;
		access(1'b1, 32'h1004, 4'b0101, 32'hdead_beef, 0);
		check_int("mem transfers", rd_delta + wr_delta, 0);
		access(1'b0, 32'h1004, 4'h0, 32'h0, 0);
		access(1'b1, 32'h8000_0048, 4'b1100, 32'h1234_5678, 0);
		check_int("mem reads", rd_delta, 1);
		access(1'b0, 32'h8000_0048, 4'h0, 32'h0, 0);
		report("byte writes", e0);

		e0 = errors;
		access(1'b0, 32'h1000, 4'h0, 32'h0, 0);
		check_int("mem transfers", rd_delta + wr_delta, 0);
		check_int("o_ack latency", last_lat, 2);
		report("repeat hit", e0);

		// set 5 untouched so far with all ways invalid and tree bits zero
		e0 = errors;
		tree = 3'b000;
		for (int w = 0; w < 4; w++)
			way_valid[w] = 1'b0;
		evicted = -1;
		for (int t = 100; t < 105; t++) begin
			v = plru_victim(tree);
			if (way_valid[v])
				evicted = way_tag[v];
			way_tag[v]   = t;
			way_valid[v] = 1'b1;
			tree = plru_touch(tree, v);
			if (t == 100)
				access(1'b1, make_addr(t, 5, 3), 4'b1001, $urandom, 0);
			else
				access(1'b0, make_addr(t, 5, 0), 4'h0, 32'h0, 0);
		end
		check_int("mem writes", wr_delta, 1);
		check_int("o_mem_addr", last_wr_addr, make_addr(evicted, 5, 0));
		for (int w = 0; w < `WORDS_PER_LINE; w++)
			check_int("o_mem_wline", last_wr_line[w*32 +: 32],
				ref_word(make_addr(evicted, 5, w)));
		access(1'b0, make_addr(evicted, 5, 3), 4'h0, 32'h0, 0);
		check_int("mem reads", rd_delta, 1);
		report("eviction", e0);

		e0 = errors;
		for (int i = 0; i < 400; i++) begin
			a = make_addr(200 + $urandom_range(0, 5), 8 + $urandom_range(0, 3),
				$urandom_range(0, 7));
			if ($urandom_range(0, 1) == 1)
				access(1'b1, a, 4'($urandom_range(1, 15)), $urandom, 0);
			else
				access(1'b0, a, 4'h0, 32'h0, 0);
		end
		report("random mix", e0);

		e0 = errors;
		n = rd_cnt + wr_cnt;
		access(1'b0, 32'h1020, 4'h0, 32'h0, 5);
		repeat (4) begin
			@(negedge clk);
			assert (!o_ack) else begin
				$display("o_ack rose again after i_req fell");
				errors++;
			end
		end
		check_int("mem transfers", rd_cnt + wr_cnt - n, 0);
		report("held request", e0);

		end_run();
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/dcache_pkg.sv
hw/mem_cmd_if.sv
hw/plru.sv
hw/tag_array.sv
hw/data_array.sv
hw/mem_bridge.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/tb_clkgen.sv
sim/dcache_asserts.sv
sim/tb_dcache.sv
